//--- src/nco_pkg.sv
/* widths, vector types, quadrant codes and the arctangent table of the CORDIC NCO,
   referenced by scoped name from each module */
package nco_pkg;

  // amplitude and output width
  localparam int sample_width = 16;
  // phase width, full circle is 2**angle_width
  localparam int angle_width = 20;
  // one rotation stage per output bit below the sign
  localparam int stage_count = sample_width - 1;
  // accumulator + fold + rotations + output register
  localparam int pipe_latency = stage_count + 3;

  typedef logic signed [sample_width-1:0] sample_t;
  // one growth bit for the CORDIC gain
  typedef logic signed [sample_width:0] wide_sample_t;
  typedef logic [angle_width-1:0] angle_t;

  // top two phase bits
  typedef enum logic [1:0] {
    q_first  = 2'b00,
    q_second = 2'b01,
    q_third  = 2'b10,
    q_fourth = 2'b11
  } quadrant_e;

  // atan(2**-i), 90 degrees = 2**(angle_width-2)
  localparam angle_t atan_table [0:stage_count-1] = '{
    20'h20000,  // 45.000 deg
    20'h12e40,  // 26.565 deg
    20'h09fb3,  // 14.036 deg
    20'h05111,
    20'h028b0,
    20'h0145d,
    20'h00a2f,
    20'h00517,
    20'h0028b,
    20'h00145,
    20'h000a2,
    20'h00051,
    20'h00028,
    20'h00014,
    20'h0000a   // last stage, about 0.0035 deg
  };

endpackage

//--- src/phase_accumulator.sv
/* phase accumulator of the NCO that steps the phase by freq_word on each enabled
   cycle and issues phase plus offset as one angle with a valid strobe */
`timescale 1ns/10ps

module phase_accumulator
(
  input  logic            clock,
  input  logic            rst_n,
  input  logic            enable,
  input  logic            sync,
  input  nco_pkg::angle_t freq_word,
  input  nco_pkg::angle_t phase_offset,
  output nco_pkg::angle_t angle,
  output logic            angle_valid
);

  // running phase wrapping modulo 2**angle_width
  nco_pkg::angle_t phase;
  nco_pkg::angle_t angle_next;

  // sync restarts from zero so the issued angle is the bare offset
  assign angle_next = sync ? phase_offset : phase + phase_offset;

  // phase register
  always_ff @(posedge clock)
  begin
    if (!rst_n)
    begin
      phase <= '0;
    end
    else if (sync)
    begin
      // cleared and already advanced by one step
      phase <= freq_word;
    end
    else if (enable)
    begin
      phase <= phase + freq_word;
    end
  end

  // angle holds its value between enabled cycles
  always_ff @(posedge clock)
  begin
    if (enable)
    begin
      angle <= angle_next;
    end
  end

  // one valid pulse per enabled edge
  always_ff @(posedge clock)
  begin
    if (!rst_n)
    begin
      angle_valid <= 1'b0;
    end
    else
    begin
      angle_valid <= enable;
    end
  end

  // valid angle only from an enabled edge out of reset
  assert property (@(posedge clock)
    angle_valid |-> $past(rst_n) && $past(enable))
    else $error("angle_valid without enable or during reset");

  // sync pulses only arrive once reset is released
  assert property (@(posedge clock)
    sync |-> rst_n)
    else $error("sync pulse while reset is held");

endmodule

//--- src/cordic_rotator.sv
/* pipelined CORDIC rotator that folds the angle into -pi/2..pi/2 and runs the
   shift-add stages to give cosine and sine scaled by the CORDIC gain */
`timescale 1ns/10ps

module cordic_rotator
(
  input  logic                  clock,
  input  logic                  rst_n,
  input  nco_pkg::angle_t       angle,
  input  logic                  angle_valid,
  input  nco_pkg::sample_t      x_start,
  output nco_pkg::wide_sample_t cos_wide,
  output nco_pkg::wide_sample_t sin_wide,
  output logic                  rot_valid
);

  // x, y and residual angle per stage with index 0 at the fold output
  nco_pkg::wide_sample_t x [0:nco_pkg::stage_count];
  nco_pkg::wide_sample_t y [0:nco_pkg::stage_count];
  nco_pkg::angle_t       z [0:nco_pkg::stage_count];

  // valid travels beside the data with bit 0 after the fold
  logic [nco_pkg::stage_count:0] valid_line;

  nco_pkg::quadrant_e    quadrant;
  nco_pkg::wide_sample_t x_ext;

  assign quadrant = nco_pkg::quadrant_e'(angle[nco_pkg::angle_width-1 -: 2]);

  // start vector lies on the x axis
  assign x_ext = nco_pkg::wide_sample_t'(x_start);

  // fold stage, y starts at zero
  always_ff @(posedge clock)
  begin
    case (quadrant)
      nco_pkg::q_second:
      begin
        // rotate start by +90 deg and take 90 deg off the angle
        x[0] <= '0;
        y[0] <= x_ext;
        z[0] <= {2'b00, angle[nco_pkg::angle_width-3:0]};
      end
      nco_pkg::q_third:
      begin
        // rotate start by -90 deg and add 90 deg to the angle
        x[0] <= '0;
        y[0] <= '0 - x_ext;
        z[0] <= {2'b11, angle[nco_pkg::angle_width-3:0]};
      end
      default:
      begin
        // first and fourth already within +-90 deg
        x[0] <= x_ext;
        y[0] <= '0;
        z[0] <= angle;
      end
    endcase
  end

  // rotation stages
  for (genvar i = 0; i < nco_pkg::stage_count; i++)
  begin : g_stage
    logic                  z_sign;
    nco_pkg::wide_sample_t x_shr;
    nco_pkg::wide_sample_t y_shr;

    // negative residual rotates clockwise
    assign z_sign = z[i][nco_pkg::angle_width-1];

    if (i == 0)
    begin : g_no_shift
      assign x_shr = x[i];
      assign y_shr = y[i];
    end
    else
    begin : g_shift
      nco_pkg::wide_sample_t x_rnd;
      nco_pkg::wide_sample_t y_rnd;

      // round half up from the last bit shifted out
      assign x_rnd = nco_pkg::wide_sample_t'(x[i][i-1]);
      assign y_rnd = nco_pkg::wide_sample_t'(y[i][i-1]);
      assign x_shr = (x[i] >>> i) + x_rnd;
      assign y_shr = (y[i] >>> i) + y_rnd;
    end

    always_ff @(posedge clock)
    begin
      if (z_sign)
      begin
        x[i+1] <= x[i] + y_shr;
        y[i+1] <= y[i] - x_shr;
        z[i+1] <= z[i] + nco_pkg::atan_table[i];
      end
      else
      begin
        x[i+1] <= x[i] - y_shr;
        y[i+1] <= y[i] + x_shr;
        z[i+1] <= z[i] - nco_pkg::atan_table[i];
      end
    end
  end

  // valid shift line with one bit per register stage
  always_ff @(posedge clock)
  begin
    if (!rst_n)
    begin
      valid_line <= '0;
    end
    else
    begin
      valid_line <= {valid_line[nco_pkg::stage_count-1:0], angle_valid};
    end
  end

  assign cos_wide  = x[nco_pkg::stage_count];
  assign sin_wide  = y[nco_pkg::stage_count];
  assign rot_valid = valid_line[nco_pkg::stage_count];

  // fold plus rotations once the line has filled after reset
  assert property (@(posedge clock) disable iff (!rst_n)
    $past(rst_n, nco_pkg::stage_count + 1)
      |-> rot_valid == $past(angle_valid, nco_pkg::stage_count + 1))
    else $error("rot_valid out of step with angle_valid");

endmodule

//--- src/output_stage.sv
/* output stage of the NCO, clamps the 17-bit rotator results to 16 bits and
   registers cosine, sine, clip and out_valid */
`timescale 1ns/10ps

module output_stage
(
  input  logic                  clock,
  input  logic                  rst_n,
  input  nco_pkg::wide_sample_t cos_wide,
  input  nco_pkg::wide_sample_t sin_wide,
  input  logic                  rot_valid,
  output nco_pkg::sample_t      cosine,
  output nco_pkg::sample_t      sine,
  output logic                  clip,
  output logic                  out_valid
);

  logic cos_over;
  logic sin_over;

  // clamp to the nearest end of the 16-bit range
  function automatic nco_pkg::sample_t saturate(input nco_pkg::wide_sample_t value);
    logic over;
    over = value[nco_pkg::sample_width] ^ value[nco_pkg::sample_width-1];
    if (over)
    begin
      // sign bit picks 32767 or -32768
      return {value[nco_pkg::sample_width], {(nco_pkg::sample_width-1){~value[nco_pkg::sample_width]}}};
    end
    return value[nco_pkg::sample_width-1:0];
  endfunction

  // growth bit differs from the sign, value outside 16 bits
  assign cos_over = cos_wide[nco_pkg::sample_width] ^ cos_wide[nco_pkg::sample_width-1];
  assign sin_over = sin_wide[nco_pkg::sample_width] ^ sin_wide[nco_pkg::sample_width-1];

  // data registers load only on valid samples
  always_ff @(posedge clock)
  begin
    if (rot_valid)
    begin
      cosine <= saturate(cos_wide);
      sine   <= saturate(sin_wide);
    end
  end

  // strobes
  always_ff @(posedge clock)
  begin
    if (!rst_n)
    begin
      clip      <= 1'b0;
      out_valid <= 1'b0;
    end
    else
    begin
      // either coordinate clamped
      clip      <= rot_valid & (cos_over | sin_over);
      out_valid <= rot_valid;
    end
  end

  assert property (@(posedge clock) disable iff (!rst_n)
    clip |-> out_valid)
    else $error("clip raised without out_valid");

endmodule

//--- src/nco_top.sv
/* top level of the CORDIC NCO, accumulator into rotator into output stage;
   amplitude must arrive one cycle after the matching enable */
`timescale 1ns/10ps

module nco_top
(
  input  logic             clock,
  input  logic             rst_n,
  input  logic             enable,
  input  logic             sync,
  input  nco_pkg::angle_t  freq_word,
  input  nco_pkg::angle_t  phase_offset,
  input  nco_pkg::sample_t amplitude,
  output nco_pkg::sample_t cosine,
  output nco_pkg::sample_t sine,
  output logic             clip,
  output logic             out_valid
);

  nco_pkg::angle_t       angle;
  logic                  angle_valid;
  nco_pkg::wide_sample_t cos_wide;
  nco_pkg::wide_sample_t sin_wide;
  logic                  rot_valid;

  phase_accumulator phase_accumulator_i
  (
    .clock        (clock),
    .rst_n        (rst_n),
    .enable       (enable),
    .sync         (sync),
    .freq_word    (freq_word),
    .phase_offset (phase_offset),
    .angle        (angle),
    .angle_valid  (angle_valid)
  );

  // amplitude sets the x start, y starts at zero inside the rotator
  cordic_rotator cordic_rotator_i
  (
    .clock       (clock),
    .rst_n       (rst_n),
    .angle       (angle),
    .angle_valid (angle_valid),
    .x_start     (amplitude),
    .cos_wide    (cos_wide),
    .sin_wide    (sin_wide),
    .rot_valid   (rot_valid)
  );

  output_stage output_stage_i
  (
    .clock     (clock),
    .rst_n     (rst_n),
    .cos_wide  (cos_wide),
    .sin_wide  (sin_wide),
    .rot_valid (rot_valid),
    .cosine    (cosine),
    .sine      (sine),
    .clip      (clip),
    .out_valid (out_valid)
  );

endmodule

//--- testbench/nco_ref.svh
/* bit-exact integer model of the NCO datapath and the stimulus LFSR,
   included inside the testbench module */
`ifndef NCO_REF_SVH
`define NCO_REF_SVH

// sign-extend the low bits of a value
function automatic int wrap_bits(input int value, input int bits);
  int shift;
  shift = 32 - bits;
  return (value <<< shift) >>> shift;
endfunction

// atan(2**-i), 90 deg = 2**18, fraction dropped
function automatic int atan_entry(input int i);
  case (i)
    0:       return 131072;
    1:       return 77376;
    2:       return 40883;
    3:       return 20753;
    4:       return 10416;
    5:       return 5213;
    6:       return 2607;
    7:       return 1303;
    8:       return 651;
    9:       return 325;
    10:      return 162;
    11:      return 81;
    12:      return 40;
    13:      return 20;
    default: return 10;
  endcase
endfunction

// clamp to the signed 16-bit range, hit marks a clamped value
function automatic int clamp16(input int value, output int hit);
  hit = (value > 32767 || value < -32768) ? 1 : 0;
  if (value > 32767)
  begin
    return 32767;
  end
  if (value < -32768)
  begin
    return -32768;
  end
  return value;
endfunction

// rotate (amp, 0) by angle in 17-bit arithmetic, then clamp both results
function automatic void cordic_model(input logic [19:0] angle, input int amp,
                                     output int cos_v, output int sin_v, output int clip_v);
  int x;
  int y;
  int z;
  int x_shr;
  int y_shr;
  int x_next;
  int cos_hit;
  int sin_hit;
  x = amp;
  y = 0;
  z = int'(angle);
  // pre-rotation by +-90 deg into the right half plane
  if (angle[19:18] == 2'b01)
  begin
    x = 0;
    y = amp;
    z = (z - 262144) & 1048575;
  end
  else if (angle[19:18] == 2'b10)
  begin
    x = 0;
    y = -amp;
    z = (z + 262144) & 1048575;
  end
  for (int i = 0; i < 15; i++)
  begin
    // round half up on the shifted copies
    x_shr = (i == 0) ? x : (x + (1 <<< (i - 1))) >>> i;
    y_shr = (i == 0) ? y : (y + (1 <<< (i - 1))) >>> i;
    if (z >= 524288)
    begin
      x_next = x + y_shr;
      y = y - x_shr;
      z = z + atan_entry(i);
    end
    else
    begin
      x_next = x - y_shr;
      y = y + x_shr;
      z = z - atan_entry(i);
    end
    x = wrap_bits(x_next, 17);
    y = wrap_bits(y, 17);
    z = z & 1048575;
  end
  cos_v = clamp16(x, cos_hit);
  sin_v = clamp16(y, sin_hit);
  clip_v = cos_hit | sin_hit;
endfunction

// Fibonacci LFSR x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] lfsr_next(input logic [15:0] state);
  return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
endfunction

`endif

//--- testbench/nco_tb.sv
/* testbench for the CORDIC NCO, drives directed and random phase words and
   checks every output sample against the integer reference model */
`timescale 1ns/10ps

module nco_tb;

  localparam int latency       = 18;
  localparam int reset_cycles  = 10;
  localparam int drain_timeout = 40;
  localparam logic [15:0] seed = 16'd187;

  logic             clock;
  logic             rst_n;
  logic             enable;
  logic             sync;
  nco_pkg::angle_t  freq_word;
  nco_pkg::angle_t  phase_offset;
  nco_pkg::sample_t amplitude;
  nco_pkg::sample_t cosine;
  nco_pkg::sample_t sine;
  logic             clip;
  logic             out_valid;

  // driver state
  logic [15:0]       lfsr_state = seed;
  logic [19:0]       model_phase = '0;
  logic signed [15:0] amp_hold = '0;
  logic              reset_req = 1'b1;
  string             test_name = "reset";
  string             out_name;
  int                edge_count = 0;
  int                checks = 0;
  int                errors = 0;

  // expected samples in issue order
  int    exp_cos_q [$];
  int    exp_sin_q [$];
  int    exp_clip_q [$];
  int    exp_edge_q [$];
  string exp_name_q [$];

  `include "nco_ref.svh"

  nco_top nco_top_i
  (
    .clock        (clock),
    .rst_n        (rst_n),
    .enable       (enable),
    .sync         (sync),
    .freq_word    (freq_word),
    .phase_offset (phase_offset),
    .amplitude    (amplitude),
    .cosine       (cosine),
    .sine         (sine),
    .clip         (clip),
    .out_valid    (out_valid)
  );

  initial
  begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  always @(posedge clock)
  begin
    edge_count <= edge_count + 1;
  end

  // LFSR stepped once per bit taken
  function automatic int random_bits(input int count);
    int value;
    value = 0;
    for (int b = 0; b < count; b++)
    begin
      lfsr_state = lfsr_next(lfsr_state);
      value = (value << 1) | lfsr_state[0];
    end
    return value;
  endfunction

  task automatic check_value(input string what, input logic signed [31:0] expected,
                             input logic signed [31:0] actual);
    checks++;
    if (actual !== expected)
    begin
      $display("CHECK FAILED %s: expected %0d, actual %0d", what, expected, actual);
      errors++;
    end
  endtask

  // one clock of stimulus, enabled cycles queue their expected sample
  task automatic drive(input logic en, input logic sy, input logic [19:0] fw,
                       input logic [19:0] po, input int amp);
    logic [19:0] angle;
    int          exp_cos;
    int          exp_sin;
    int          exp_clip;
    @(posedge clock);
    rst_n        <= !reset_req;
    enable       <= en;
    sync         <= sy;
    freq_word    <= fw;
    phase_offset <= po;
    // amplitude trails its enable by one cycle
    amplitude    <= amp_hold;
    amp_hold = amp;
    angle = sy ? po : model_phase + po;
    if (reset_req)
    begin
      model_phase = '0;
    end
    else
    begin
      if (en)
      begin
        cordic_model(angle, amp, exp_cos, exp_sin, exp_clip);
        exp_cos_q.push_back(exp_cos);
        exp_sin_q.push_back(exp_sin);
        exp_clip_q.push_back(exp_clip);
        // this edge is edge_count + 1
        exp_edge_q.push_back(edge_count + 1 + latency);
        exp_name_q.push_back(test_name);
      end
      // sync restarts the phase one step in
      if (sy)
      begin
        model_phase = fw;
      end
      else if (en)
      begin
        model_phase = model_phase + fw;
      end
    end
  endtask

  // boundary of each quadrant and either side of it
  task automatic sweep_axes(input int amp, input int delta);
    for (int q = 0; q < 4; q++)
    begin
      drive(1'b1, 1'b0, '0, q * 262144, amp);
      drive(1'b1, 1'b0, '0, q * 262144 + delta, amp);
      drive(1'b1, 1'b0, '0, q * 262144 - delta, amp);
    end
  endtask

  task automatic drain(input int limit);
    int waited;
    waited = 0;
    while (exp_edge_q.size() > 0 && waited < limit)
    begin
      drive(1'b0, 1'b0, '0, '0, 0);
      waited++;
    end
    if (exp_edge_q.size() > 0)
    begin
      $display("timed out after %0d cycles with %0d samples still outstanding",
               waited, exp_edge_q.size());
      errors++;
    end
  endtask

  // outputs settle after the rising edge, sampled on the falling one
  always @(negedge clock)
  begin
    if (!rst_n)
    begin
      check_value("reset out_valid", 0, out_valid);
    end
    if (out_valid === 1'b1)
    begin
      if (exp_edge_q.size() == 0)
      begin
        $display("out_valid high at cycle %0d with no sample outstanding", edge_count);
        errors++;
      end
      else
      begin
        out_name = exp_name_q.pop_front();
        check_value({out_name, " latency"}, exp_edge_q.pop_front(), edge_count);
        check_value({out_name, " cosine"}, exp_cos_q.pop_front(), cosine);
        check_value({out_name, " sine"}, exp_sin_q.pop_front(), sine);
        check_value({out_name, " clip"}, exp_clip_q.pop_front(), clip);
      end
    end
    else
    begin
      check_value("clip while idle", 0, clip);
      // slot went by without out_valid
      if (exp_edge_q.size() > 0 && exp_edge_q[0] <= edge_count)
      begin
        $display("%s sample due at cycle %0d never appeared", exp_name_q[0], exp_edge_q[0]);
        errors++;
        void'(exp_name_q.pop_front());
        void'(exp_edge_q.pop_front());
        void'(exp_cos_q.pop_front());
        void'(exp_sin_q.pop_front());
        void'(exp_clip_q.pop_front());
      end
    end
  end

  initial
  begin
    int   fw;
    int   po;
    int   amp;
    logic en;
    logic sy;
    rst_n = 1'b0;
    enable = 1'b0;
    sync = 1'b0;
    freq_word = '0;
    phase_offset = '0;
    amplitude = '0;
    // rst_n already low for the first edge
    repeat (reset_cycles - 1) drive(1'b0, 1'b0, '0, '0, 0);
    reset_req = 1'b0;

    // wraps about every 14 samples
    test_name = "accumulation";
    repeat (40) drive(1'b1, 1'b0, 20'h12345, 20'h01000, 18000);
    fw = random_bits(20);
    repeat (30) drive(1'b1, 1'b0, fw, 20'h00000, 12000);

    test_name = "quadrant folding";
    drive(1'b1, 1'b1, '0, '0, 25000);
    sweep_axes(25000, 1);
    sweep_axes(25000, 131072);

    // gain pushes the axis samples past full scale
    test_name = "saturation";
    sweep_axes(32767, 256);
    sweep_axes(32000, 256);
    sweep_axes(20000, 256);
    sweep_axes(19800, 256);
    sweep_axes(-32768, 256);

    test_name = "sync";
    fw = random_bits(20);
    repeat (12) drive(1'b1, 1'b0, fw, 20'h31000, 16000);
    drive(1'b1, 1'b1, fw, 20'h31000, 16000);
    repeat (12) drive(1'b1, 1'b0, fw, 20'h31000, 16000);
    // restart on an idle cycle
    drive(1'b0, 1'b1, fw, 20'h31000, 16000);
    repeat (8) drive(1'b1, 1'b0, fw, 20'h31000, 16000);

    test_name = "enable gaps";
    fw = random_bits(20);
    for (int n = 0; n < 200; n++)
    begin
      en = (random_bits(2) != 0);
      sy = (random_bits(5) == 0);
      po = random_bits(20);
      amp = wrap_bits(random_bits(16), 16);
      drive(en, sy, fw, po, amp);
    end
    drain(drain_timeout);

    // enable held high through a reset on an empty pipeline
    test_name = "reset";
    reset_req = 1'b1;
    repeat (reset_cycles) drive(1'b1, 1'b0, 20'h0a000, '0, 15000);
    reset_req = 1'b0;
    repeat (6) drive(1'b1, 1'b0, 20'h0a000, '0, 15000);
    drain(drain_timeout);

    // no stray out_valid after the last sample
    repeat (latency) drive(1'b0, 1'b0, '0, '0, 0);
    check_value("queue empty", 0, exp_edge_q.size());

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
    begin
      $display("NO ERRORS");
    end
    else
    begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

//--- build.f
+incdir+testbench
src/nco_pkg.sv
src/phase_accumulator.sv
src/cordic_rotator.sv
src/output_stage.sv
src/nco_top.sv
testbench/nco_tb.sv
